// ==== Bender.yml ====
package:
  name: exec_core

sources:
  - files:
      - rtl/exec_pkg.sv
      - rtl/alu.sv
      - rtl/reg_file.sv
      - rtl/hazard_unit.sv
      - rtl/exec.sv
      - rtl/id_ex_stage.sv
      - rtl/mem_wb_stage.sv
      - rtl/exec_core.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - dv/tb_exec_core.sv

// ==== include/tb_ref_model.svh ====
// architectural state of the in-order model
logic [31:0] model_regs [32];
logic        model_flush;

function automatic exec_pkg::instr_t alu_instr(
    input exec_pkg::alu_op_t op,
    input logic [4:0]        rd,
    input logic [4:0]        rs1,
    input logic [4:0]        rs2,
    input logic [31:0]       imm,
    input logic              use_imm,
    input logic              use_pc
);
    exec_pkg::instr_t instr;
    instr = '0;
    instr.valid = 1'b1;
    instr.ctrl.reg_write = 1'b1;
    instr.ctrl.alu_src = use_imm;
    instr.ctrl.src_a_pc = use_pc;
    instr.ctrl.alu_control = op;
    instr.rs1 = rs1;
    instr.rs2 = rs2;
    instr.rd = rd;
    instr.imm = imm;
    return instr;
endfunction

// sub for beq/bne, slt for blt/bge, sltu for bltu/bgeu
function automatic exec_pkg::instr_t branch_instr(
    input exec_pkg::alu_op_t op,
    input logic              inv,
    input logic [4:0]        rs1,
    input logic [4:0]        rs2,
    input logic [31:0]       imm
);
    exec_pkg::instr_t instr;
    instr = alu_instr(op, 5'd0, rs1, rs2, imm, 1'b0, 1'b0);
    instr.ctrl.reg_write = 1'b0;
    instr.ctrl.branch = 1'b1;
    instr.ctrl.funct3_0 = inv;
    return instr;
endfunction

function automatic exec_pkg::instr_t jal_instr(input logic [4:0] rd, input logic [31:0] imm);
    exec_pkg::instr_t instr;
    instr = alu_instr(exec_pkg::ALU_ADD, rd, 5'd0, 5'd0, imm, 1'b1, 1'b1);
    instr.ctrl.result_src = exec_pkg::RES_PC4;
    instr.ctrl.jump = 1'b1;
    return instr;
endfunction

task automatic model_reset();
    for (int i = 0; i < 32; i++) begin
        model_regs[i] = '0;
    end
    model_flush = 1'b0;
endtask

// one accepted slot, executed under the ISA rules
task automatic model_accept(
    input  exec_pkg::instr_t instr,
    output exec_pkg::wb_t    result,
    output logic             redir,
    output logic [31:0]      target
);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    logic        cond;
    result = '0;
    redir = 1'b0;
    target = instr.pc + instr.imm;
    if (instr.valid && !model_flush) begin
        a = instr.ctrl.src_a_pc ? instr.pc : model_regs[instr.rs1];
        b = instr.ctrl.alu_src ? instr.imm : model_regs[instr.rs2];
        case (instr.ctrl.alu_control)
            exec_pkg::ALU_ADD:    r = a + b;
            exec_pkg::ALU_SUB:    r = a - b;
            exec_pkg::ALU_AND:    r = a & b;
            exec_pkg::ALU_OR:     r = a | b;
            exec_pkg::ALU_SLTU:   r = {31'd0, a < b};
            exec_pkg::ALU_SLT:    r = {31'd0, $signed(a) < $signed(b)};
            exec_pkg::ALU_XOR:    r = a ^ b;
            exec_pkg::ALU_SLL:    r = a << b[4:0];
            exec_pkg::ALU_SRL:    r = a >> b[4:0];
            exec_pkg::ALU_SRA:    r = $signed(a) >>> b[4:0];
            exec_pkg::ALU_PASS_B: r = b;
            default:              r = '0;
        endcase
        case (instr.ctrl.alu_control)
            exec_pkg::ALU_SLT:  cond = $signed(a) < $signed(b);
            exec_pkg::ALU_SLTU: cond = a < b;
            default:            cond = (a == b);
        endcase
        redir = instr.ctrl.jump | (instr.ctrl.branch & (cond ^ instr.ctrl.funct3_0));
        result.valid = 1'b1;
        result.we = instr.ctrl.reg_write;
        result.rd = instr.rd;
        result.data = (instr.ctrl.result_src == exec_pkg::RES_PC4) ? instr.pc + 32'd4 : r;
        if (instr.ctrl.reg_write && instr.rd != 5'd0) begin
            model_regs[instr.rd] = result.data;
        end
    end
    // the slot right behind a redirect is dropped
    model_flush = redir;
endtask

// ==== dv/tb_exec_core.sv ====
`timescale 1ns/10ps

module tb_exec_core;

    logic             clk;
    logic             reset;
    exec_pkg::instr_t instr_in;
    logic             redirect_valid;
    logic [31:0]      redirect_pc;
    exec_pkg::wb_t    wb;

    integer           seed = 32'h1fe3b45e;
    int               checks = 0;
    int               errors = 0;
    int               timeouts = 0;
    logic [31:0]      pc_cnt;
    exec_pkg::wb_t    exp_wb [3];
    logic             exp_redir;
    logic [31:0]      exp_target;

    `include "tb_ref_model.svh"

    exec_core #(
        .NUM_REGS (32)
    ) i_exec_core (
        .clk            (clk),
        .reset          (reset),
        .instr_in       (instr_in),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .wb             (wb)
    );

    always #4 clk = ~clk;

    // model follows the slot sampled at each edge, wb lags by 3
    always @(posedge clk) begin
        exec_pkg::wb_t e;
        logic          r;
        logic [31:0]   t;
        if (reset) begin
            model_reset();
            exp_wb[0] = '0;
            exp_wb[1] = '0;
            exp_wb[2] = '0;
            exp_redir = 1'b0;
        end else begin
            model_accept(instr_in, e, r, t);
            exp_wb[2] = exp_wb[1];
            exp_wb[1] = exp_wb[0];
            exp_wb[0] = e;
            exp_redir = r;
            exp_target = t;
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("Fail %0t %s expected %h actual %h", $time, name, expected, actual);
    endtask

    always @(negedge clk) begin
        checks++;
        a_wb_valid: assert (wb.valid === exp_wb[2].valid)
            else report_mismatch("wb.valid", exp_wb[2].valid, wb.valid);
        a_wb_we: assert (wb.we === exp_wb[2].we)
            else report_mismatch("wb.we", exp_wb[2].we, wb.we);
        if (exp_wb[2].we) begin
            a_wb_rd: assert (wb.rd === exp_wb[2].rd)
                else report_mismatch("wb.rd", exp_wb[2].rd, wb.rd);
            a_wb_data: assert (wb.data === exp_wb[2].data)
                else report_mismatch("wb.data", exp_wb[2].data, wb.data);
        end
        a_redirect: assert (redirect_valid === exp_redir)
            else report_mismatch("redirect_valid", exp_redir, redirect_valid);
        if (exp_redir) begin
            a_redirect_pc: assert (redirect_pc === exp_target)
                else report_mismatch("redirect_pc", exp_target, redirect_pc);
        end
    end

    task automatic issue(input exec_pkg::instr_t instr);
        instr.pc = pc_cnt;
        @(posedge clk);
        instr_in <= instr;
        pc_cnt = pc_cnt + 32'd4;
    endtask

    // bumps x8, so a slot that should be flushed shows up in later results
    function automatic exec_pkg::instr_t filler();
        return alu_instr(exec_pkg::ALU_ADD, 5'd8, 5'd8, 5'd0, 32'd1, 1'b1, 1'b0);
    endfunction

    task automatic directed_tests();
        exec_pkg::alu_op_t op;
        issue(alu_instr(exec_pkg::ALU_ADD, 5'd1, 5'd0, 5'd0, 32'd25, 1'b1, 1'b0));
        issue(alu_instr(exec_pkg::ALU_ADD, 5'd2, 5'd0, 5'd0, 32'hffff_fff3, 1'b1, 1'b0));
        issue(alu_instr(exec_pkg::ALU_ADD, 5'd3, 5'd0, 5'd0, 32'd25, 1'b1, 1'b0));
        issue(alu_instr(exec_pkg::ALU_PASS_B, 5'd4, 5'd0, 5'd0, 32'h8000_0f0f, 1'b1, 1'b0));
        for (int k = 0; k <= 10; k++) begin
            op = exec_pkg::alu_op_t'(k[3:0]);
            issue(alu_instr(op, 5'd10, 5'd4, 5'd2, 32'd0, 1'b0, 1'b0));
            issue(alu_instr(op, 5'd11, 5'd2, 5'd0, 32'd7, 1'b1, 1'b0));
            issue(alu_instr(op, 5'd12, 5'd0, 5'd1, 32'd0, 1'b0, 1'b1));
        end
        // dependency at distance 1, 2 and 3 through rs1, then rs2
        for (int d = 1; d <= 3; d++) begin
            for (int p = 0; p < 2; p++) begin
                // fresh x5 value on every pass
                issue(alu_instr(exec_pkg::ALU_ADD, 5'd5, 5'd1, 5'd0, 32'd100 + 2 * d + p,
                                1'b1, 1'b0));
                repeat (d - 1) begin
                    issue(alu_instr(exec_pkg::ALU_XOR, 5'd9, 5'd2, 5'd3, '0, 1'b0, 1'b0));
                end
                issue(alu_instr(exec_pkg::ALU_SUB, 5'd6, p ? 5'd1 : 5'd5, p ? 5'd5 : 5'd1,
                                '0, 1'b0, 1'b0));
            end
        end
        issue(alu_instr(exec_pkg::ALU_ADD, 5'd0, 5'd1, 5'd0, 32'd77, 1'b1, 1'b0));
        repeat (3) issue(alu_instr(exec_pkg::ALU_OR, 5'd7, 5'd0, 5'd0, '0, 1'b0, 1'b0));
        for (int k = 0; k < 3; k++) begin
            op = (k == 0) ? exec_pkg::ALU_SUB
               : ((k == 1) ? exec_pkg::ALU_SLT : exec_pkg::ALU_SLTU);
            for (int inv = 0; inv < 2; inv++) begin
                issue(branch_instr(op, inv[0], 5'd1, 5'd3, 32'd64));
                issue(filler());
                issue(branch_instr(op, inv[0], 5'd1, 5'd2, 32'hffff_fff0));
                issue(filler());
                issue(branch_instr(op, inv[0], 5'd2, 5'd1, 32'd8));
                issue(filler());
            end
        end
        issue(jal_instr(5'd13, 32'd2048));
        issue(filler());
        issue(alu_instr(exec_pkg::ALU_ADD, 5'd14, 5'd13, 5'd8, '0, 1'b0, 1'b0));
    endtask

    task automatic random_stream(input int count);
        logic [31:0] rnd;
        logic [31:0] imm;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [3:0]  op_bits;
        exec_pkg::alu_op_t br_op;
        for (int n = 0; n < count; n++) begin
            rnd = $random(seed);
            imm = $random(seed);
            rd = {2'b00, rnd[5:3]};
            rs1 = {2'b00, rnd[8:6]};
            rs2 = {2'b00, rnd[11:9]};
            op_bits = rnd[15:12] % 4'd11;
            br_op = (rnd[17:16] == 2'd0) ? exec_pkg::ALU_SUB
                  : ((rnd[17:16] == 2'd1) ? exec_pkg::ALU_SLT : exec_pkg::ALU_SLTU);
            case (rnd[2:0])
                3'd6: issue(branch_instr(br_op, rnd[18], rs1, rs2, {imm[11:2], 2'b00}));
                3'd7: issue(jal_instr(rd, {imm[19:2], 2'b00}));
                default: issue(alu_instr(exec_pkg::alu_op_t'(op_bits), rd, rs1, rs2, imm,
                                         rnd[2], rnd[19] & rnd[20]));
            endcase
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        @(posedge clk);
        instr_in <= '0;
        @(negedge clk);
        while ((wb.valid !== 1'b0 || exp_wb[0].valid || exp_wb[1].valid || exp_wb[2].valid)
               && waited < 16) begin
            @(negedge clk);
            waited++;
        end
        if (waited >= 16) begin
            timeouts++;
            $display("timeout: the pipeline did not drain");
        end
        @(posedge clk);
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        instr_in = '0;
        pc_cnt = 32'h0000_1000;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        directed_tests();
        random_stream(400);
        drain();
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== rtl/alu.sv ====
`timescale 1ns/10ps

module alu (
    input  logic [31:0]      a,
    input  logic [31:0]      b,
    input  exec_pkg::alu_op_t alu_control,
    output logic [31:0]      result,
    output logic             zero
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (alu_control)
            exec_pkg::ALU_ADD: begin
                result = a + b;
            end
            exec_pkg::ALU_SUB: begin
                result = a - b;
            end
            exec_pkg::ALU_AND: begin
                result = a & b;
            end
            exec_pkg::ALU_OR: begin
                result = a | b;
            end
            exec_pkg::ALU_SLTU: begin
                result = {31'd0, (a < b)};
            end
            exec_pkg::ALU_SLT: begin
                result = {31'd0, ($signed(a) < $signed(b))};
            end
            exec_pkg::ALU_XOR: begin
                result = a ^ b;
            end
            exec_pkg::ALU_SLL: begin
                result = a << shamt;
            end
            exec_pkg::ALU_SRL: begin
                result = a >> shamt;
            end
            exec_pkg::ALU_SRA: begin
                result = $unsigned($signed(a) >>> shamt);
            end
            exec_pkg::ALU_PASS_B: begin
                result = b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // beq/bne look at this after a sub
    assign zero = (result == 32'd0);

endmodule

// ==== rtl/exec.sv ====
`timescale 1ns/10ps

module exec (
    input  exec_pkg::instr_t     id_ex,
    input  exec_pkg::fwd_sel_t   forward_a,
    input  exec_pkg::fwd_sel_t   forward_b,
    input  logic [31:0]          mem_alu_result,
    input  logic [31:0]          wb_data,
    output exec_pkg::ex_result_t ex_out,
    output logic                 redirect_valid,
    output logic [31:0]          redirect_pc
);

    logic [31:0] fwd_a;
    logic [31:0] fwd_b;
    logic [31:0] src_a;
    logic [31:0] src_b;
    logic [31:0] alu_result;
    logic        zero;
    logic        branch_met;

    function automatic logic [31:0] fwd_mux(
        input exec_pkg::fwd_sel_t sel,
        input logic [31:0]        reg_val
    );
        logic [31:0] value;
        case (sel)
            exec_pkg::FWD_WB: begin
                value = wb_data;
            end
            exec_pkg::FWD_MEM: begin
                value = mem_alu_result;
            end
            default: begin
                value = reg_val;
            end
        endcase
        return value;
    endfunction

    always_comb begin
        fwd_a = fwd_mux(forward_a, id_ex.rd1);
        fwd_b = fwd_mux(forward_b, id_ex.rd2);
    end

    // auipc/jal take pc, i-type and jal take imm
    assign src_a = id_ex.ctrl.src_a_pc ? id_ex.pc : fwd_a;
    assign src_b = id_ex.ctrl.alu_src ? id_ex.imm : fwd_b;

    alu i_alu (
        .a           (src_a),
        .b           (src_b),
        .alu_control (id_ex.ctrl.alu_control),
        .result      (alu_result),
        .zero        (zero)
    );

    always_comb begin
        case (id_ex.ctrl.alu_control)
            // beq, bne
            exec_pkg::ALU_SUB: begin
                branch_met = id_ex.ctrl.funct3_0 ^ zero;
            end
            // blt, bge
            exec_pkg::ALU_SLT: begin
                branch_met = id_ex.ctrl.funct3_0 ^ alu_result[0];
            end
            // bltu, bgeu
            exec_pkg::ALU_SLTU: begin
                branch_met = id_ex.ctrl.funct3_0 ^ alu_result[0];
            end
            default: begin
                branch_met = 1'b0;
            end
        endcase
    end

    assign redirect_valid = id_ex.valid &
                            ((id_ex.ctrl.branch & branch_met) | id_ex.ctrl.jump);
    assign redirect_pc    = id_ex.pc + id_ex.imm;

    always_comb begin
        ex_out.valid      = id_ex.valid;
        ex_out.reg_write  = id_ex.ctrl.reg_write;
        ex_out.result_src = id_ex.ctrl.result_src;
        ex_out.rd         = id_ex.rd;
        ex_out.alu_result = alu_result;
        ex_out.pc_plus4   = id_ex.pc + 32'd4;
    end

endmodule

// ==== rtl/exec_core.sv ====
`timescale 1ns/10ps

module exec_core #(
    parameter int NUM_REGS = 32
) (
    input  logic             clk,
    input  logic             reset,
    input  exec_pkg::instr_t instr_in,
    output logic             redirect_valid,
    output logic [31:0]      redirect_pc,
    output exec_pkg::wb_t    wb
);

    exec_pkg::instr_t     id_ex;
    exec_pkg::ex_result_t ex_out;
    exec_pkg::fwd_sel_t   forward_a;
    exec_pkg::fwd_sel_t   forward_b;
    logic [4:0]           rs1;
    logic [4:0]           rs2;
    logic [31:0]          rd1;
    logic [31:0]          rd2;
    logic [4:0]           mem_rd;
    logic                 mem_reg_write;
    logic [31:0]          mem_alu_result;

    reg_file #(
        .NUM_REGS (NUM_REGS)
    ) i_reg_file (
        .clk     (clk),
        .reset   (reset),
        .raddr_a (rs1),
        .raddr_b (rs2),
        .rdata_a (rd1),
        .rdata_b (rd2),
        .wr      (wb)
    );

    id_ex_stage i_id_ex_stage (
        .clk      (clk),
        .reset    (reset),
        .instr_in (instr_in),
        .flush    (redirect_valid),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd1      (rd1),
        .rd2      (rd2),
        .id_ex    (id_ex)
    );

    hazard_unit i_hazard_unit (
        .rs1_e       (id_ex.rs1),
        .rs2_e       (id_ex.rs2),
        .rd_m        (mem_rd),
        .reg_write_m (mem_reg_write),
        .rd_w        (wb.rd),
        .reg_write_w (wb.we),
        .forward_a   (forward_a),
        .forward_b   (forward_b)
    );

    exec i_exec (
        .id_ex          (id_ex),
        .forward_a      (forward_a),
        .forward_b      (forward_b),
        .mem_alu_result (mem_alu_result),
        .wb_data        (wb.data),
        .ex_out         (ex_out),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    mem_wb_stage i_mem_wb_stage (
        .clk            (clk),
        .reset          (reset),
        .ex_out         (ex_out),
        .mem_rd         (mem_rd),
        .mem_reg_write  (mem_reg_write),
        .mem_alu_result (mem_alu_result),
        .wb             (wb)
    );

endmodule

// ==== rtl/exec_pkg.sv ====
package exec_pkg;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'b0000,
        ALU_SUB    = 4'b0001,
        ALU_AND    = 4'b0010,
        ALU_OR     = 4'b0011,
        ALU_SLTU   = 4'b0100,
        ALU_SLT    = 4'b0101,
        ALU_XOR    = 4'b0110,
        ALU_SLL    = 4'b0111,
        ALU_SRL    = 4'b1000,
        ALU_SRA    = 4'b1001,
        // lui goes through operand b unchanged
        ALU_PASS_B = 4'b1010
    } alu_op_t;

    typedef enum logic {
        RES_ALU = 1'b0,
        RES_PC4 = 1'b1
    } result_src_t;

    typedef struct packed {
        logic        reg_write;
        result_src_t result_src;
        logic        alu_src;
        logic        src_a_pc;
        alu_op_t     alu_control;
        logic        branch;
        logic        jump;
        logic        funct3_0;
    } decode_ctrl_t;

    // rd1/rd2 are zero from decode, filled at the id/ex register
    typedef struct packed {
        logic         valid;
        decode_ctrl_t ctrl;
        logic [4:0]   rs1;
        logic [4:0]   rs2;
        logic [4:0]   rd;
        logic [31:0]  imm;
        logic [31:0]  pc;
        logic [31:0]  rd1;
        logic [31:0]  rd2;
    } instr_t;

    typedef struct packed {
        logic        valid;
        logic        reg_write;
        result_src_t result_src;
        logic [4:0]  rd;
        logic [31:0] alu_result;
        logic [31:0] pc_plus4;
    } ex_result_t;

    typedef struct packed {
        logic        valid;
        logic        we;
        logic [4:0]  rd;
        logic [31:0] data;
    } wb_t;

    typedef enum logic [1:0] {
        FWD_REG = 2'b00,
        FWD_WB  = 2'b01,
        FWD_MEM = 2'b10
    } fwd_sel_t;

endpackage

// ==== rtl/hazard_unit.sv ====
`timescale 1ns/10ps

module hazard_unit (
    input  logic [4:0]          rs1_e,
    input  logic [4:0]          rs2_e,
    input  logic [4:0]          rd_m,
    input  logic                reg_write_m,
    input  logic [4:0]          rd_w,
    input  logic                reg_write_w,
    output exec_pkg::fwd_sel_t  forward_a,
    output exec_pkg::fwd_sel_t  forward_b
);

    // memory stage is younger, so it wins over writeback
    function automatic exec_pkg::fwd_sel_t pick(
        input logic [4:0] rs,
        input logic [4:0] rd_mem,
        input logic       we_mem,
        input logic [4:0] rd_wb,
        input logic       we_wb
    );
        exec_pkg::fwd_sel_t sel;
        if (rs == 5'd0) begin
            sel = exec_pkg::FWD_REG;
        end else if (we_mem && (rd_mem == rs)) begin
            sel = exec_pkg::FWD_MEM;
        end else if (we_wb && (rd_wb == rs)) begin
            sel = exec_pkg::FWD_WB;
        end else begin
            sel = exec_pkg::FWD_REG;
        end
        return sel;
    endfunction

    always_comb begin
        forward_a = pick(rs1_e, rd_m, reg_write_m, rd_w, reg_write_w);
        forward_b = pick(rs2_e, rd_m, reg_write_m, rd_w, reg_write_w);
    end

endmodule

// ==== rtl/id_ex_stage.sv ====
`timescale 1ns/10ps

module id_ex_stage (
    input  logic             clk,
    input  logic             reset,
    input  exec_pkg::instr_t instr_in,
    input  logic             flush,
    output logic [4:0]       rs1,
    output logic [4:0]       rs2,
    input  logic [31:0]      rd1,
    input  logic [31:0]      rd2,
    output exec_pkg::instr_t id_ex
);

    exec_pkg::instr_t payload;

    // register file is read straight from the incoming instruction
    assign rs1 = instr_in.rs1;
    assign rs2 = instr_in.rs2;

    // flush drops the instruction behind a taken branch or jal
    always_ff @(posedge clk) begin
        if (reset) begin
            payload.valid <= 1'b0;
        end else begin
            payload.valid <= instr_in.valid & ~flush;
        end
        payload.ctrl <= instr_in.ctrl;
        payload.rs1  <= instr_in.rs1;
        payload.rs2  <= instr_in.rs2;
        payload.rd   <= instr_in.rd;
        payload.imm  <= instr_in.imm;
        payload.pc   <= instr_in.pc;
        payload.rd1  <= rd1;
        payload.rd2  <= rd2;
    end

    assign id_ex = payload;

endmodule

// ==== rtl/mem_wb_stage.sv ====
`timescale 1ns/10ps

module mem_wb_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  exec_pkg::ex_result_t ex_out,
    output logic [4:0]           mem_rd,
    output logic                 mem_reg_write,
    output logic [31:0]          mem_alu_result,
    output exec_pkg::wb_t        wb
);

    exec_pkg::ex_result_t ex_mem;
    logic                 wb_valid;
    logic                 wb_we;
    logic [4:0]           wb_rd;
    logic [31:0]          wb_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_mem.valid <= 1'b0;
        end else begin
            ex_mem.valid <= ex_out.valid;
        end
        ex_mem.reg_write  <= ex_out.reg_write;
        ex_mem.result_src <= ex_out.result_src;
        ex_mem.rd         <= ex_out.rd;
        ex_mem.alu_result <= ex_out.alu_result;
        ex_mem.pc_plus4   <= ex_out.pc_plus4;
    end

    // forwarding source one stage behind execute
    assign mem_rd         = ex_mem.rd;
    assign mem_reg_write  = ex_mem.valid & ex_mem.reg_write;
    assign mem_alu_result = ex_mem.alu_result;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
            wb_we    <= 1'b0;
        end else begin
            wb_valid <= ex_mem.valid;
            wb_we    <= ex_mem.valid & ex_mem.reg_write;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd   <= ex_mem.rd;
        wb_data <= (ex_mem.result_src == exec_pkg::RES_PC4) ? ex_mem.pc_plus4
                                                            : ex_mem.alu_result;
    end

    always_comb begin
        wb.valid = wb_valid;
        wb.we    = wb_we;
        wb.rd    = wb_rd;
        wb.data  = wb_data;
    end

endmodule

// ==== rtl/reg_file.sv ====
`timescale 1ns/10ps

module reg_file #(
    parameter int NUM_REGS = 32
) (
    input  logic          clk,
    input  logic          reset,
    input  logic [4:0]    raddr_a,
    input  logic [4:0]    raddr_b,
    output logic [31:0]   rdata_a,
    output logic [31:0]   rdata_b,
    input  exec_pkg::wb_t wr
);

    localparam int AW = $clog2(NUM_REGS);

    logic [31:0] regs [NUM_REGS];
    logic        wr_en;

    // x0 and out-of-range targets never land
    assign wr_en = wr.valid && wr.we && (wr.rd != 5'd0) && (wr.rd < NUM_REGS);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr.rd[AW-1:0]] <= wr.data;
        end
    end

    function automatic logic [31:0] read_reg(input logic [4:0] addr);
        logic [31:0] value;
        if ((addr == 5'd0) || (addr >= NUM_REGS)) begin
            value = '0;
        end else if (wr_en && (wr.rd == addr)) begin
            // same-cycle write shows through
            value = wr.data;
        end else begin
            value = regs[addr[AW-1:0]];
        end
        return value;
    endfunction

    always_comb begin
        rdata_a = read_reg(raddr_a);
        rdata_b = read_reg(raddr_b);
    end

endmodule

// ==== src.f ====
+incdir+include
rtl/exec_pkg.sv
rtl/alu.sv
rtl/reg_file.sv
rtl/hazard_unit.sv
rtl/exec.sv
rtl/id_ex_stage.sv
rtl/mem_wb_stage.sv
rtl/exec_core.sv
dv/tb_exec_core.sv
